// ==== hdl/rf_defines.svh ====
// Sizing macros for the register-file stage: data width, register count, queue depths
`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// --------------------
// Architectural sizes
// --------------------
// Integer data width
`define RF_XLEN 32
// Number of integer registers, x0 included
`define RF_XREG_NUM 32
// Register index width
`define RF_REG_IDX_LEN 5

// --------------------
// Pipeline sizes
// --------------------
`define RF_TAG_LEN 4
`define RF_ISSUE_DEPTH 4
`define RF_COMMIT_DEPTH 4

`endif

// ==== hdl/isa_pkg.sv ====
// Architectural types of the integer core: register index and data word
`default_nettype none

`include "rf_defines.svh"

package isa_pkg;

  // --------------------
  // Register index
  // --------------------
  // Selects one of the integer registers
  // Index zero is the hardwired zero register
  typedef logic [`RF_REG_IDX_LEN-1:0] reg_idx_t;

  // --------------------
  // Data word
  // --------------------
  // Width of one integer register and of each operand
  typedef logic [`RF_XLEN-1:0] xword_t;

endpackage

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
// Pipeline packet types: instruction tag, issue request, issue packet, commit record
`default_nettype none

`include "rf_defines.svh"

package pipe_pkg;

  // Instruction tag, carried from request to packet
  typedef logic [`RF_TAG_LEN-1:0] tag_t;

  // --------------------
  // Issue side
  // --------------------
  // Request from the issue queue, source indices only
  typedef struct packed {
    tag_t              tag;
    isa_pkg::reg_idx_t rs1_idx;
    isa_pkg::reg_idx_t rs2_idx;
  } issue_req_t;

  // Packet sent to execution, operand values resolved
  typedef struct packed {
    tag_t            tag;
    isa_pkg::xword_t rs1_value;
    isa_pkg::xword_t rs2_value;
  } issue_pkt_t;

  // --------------------
  // Commit side
  // --------------------
  // Result to be written back into the register file
  typedef struct packed {
    isa_pkg::reg_idx_t rd_idx;
    isa_pkg::xword_t   rd_value;
  } commit_t;

endpackage

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
// Synchronous circular-buffer FIFO with a type-parameterized payload
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Write side
  input  logic     push_i,
  input  payload_t wdata_i,
  output logic     full_o,

  // Read side, head always visible
  input  logic     pop_i,
  output payload_t rdata_o,
  output logic     valid_o
);

  // Pointer and occupancy widths
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Storage, payload only so no reset
  payload_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Qualified operations
  logic push_ok;
  logic pop_ok;

  // --------------------
  // Status
  // --------------------
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign rdata_o = mem_q[rd_ptr_q];

  // Ignore push when full and pop when empty
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && valid_o;

  // --------------------
  // Storage write
  // --------------------
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Wrap at the last slot, DEPTH need not be a power of two
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/int_rf.sv ====
// Integer register file: one synchronous write port, two combinational read ports
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module int_rf (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Write port from the commit queue
  input  logic              wr_valid_i,
  input  pipe_pkg::commit_t wr_i,

  // Read ports to the issue stage
  input  isa_pkg::reg_idx_t rs1_idx_i,
  input  isa_pkg::reg_idx_t rs2_idx_i,
  output isa_pkg::xword_t   rs1_value_o,
  output isa_pkg::xword_t   rs2_value_o
);

  // Registers x1 and up, x0 has no storage
  isa_pkg::xword_t rf_q [1:`RF_XREG_NUM-1];

  // Write enable, writes to x0 dropped
  logic wr_en;

  assign wr_en = wr_valid_i && (wr_i.rd_idx != '0);

  // --------------------
  // Write port
  // --------------------
  // Whole file cleared on reset so every register reads zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `RF_XREG_NUM; i++) begin
        rf_q[i] <= '0;
      end
    end else if (wr_en) begin
      rf_q[wr_i.rd_idx] <= wr_i.rd_value;
    end
  end

  // --------------------
  // Read ports
  // --------------------
  // Value written at the preceding edge is already visible
  always_comb begin
    // rs1
    if (rs1_idx_i != '0) begin
      rs1_value_o = rf_q[rs1_idx_i];
    end else begin
      rs1_value_o = '0;
    end
    // rs2
    if (rs2_idx_i != '0) begin
      rs2_value_o = rf_q[rs2_idx_i];
    end else begin
      rs2_value_o = '0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/operand_fetch.sv ====
// Operand fetch stage: register file read and issue packet output register
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Request from the issue queue head
  input  logic                 req_valid_i,
  input  pipe_pkg::issue_req_t req_i,
  output logic                 req_pop_o,

  // Register file read ports
  output isa_pkg::reg_idx_t    rs1_idx_o,
  output isa_pkg::reg_idx_t    rs2_idx_o,
  input  isa_pkg::xword_t      rs1_value_i,
  input  isa_pkg::xword_t      rs2_value_i,

  // Issue packet to execution
  output logic                 pkt_valid_o,
  output pipe_pkg::issue_pkt_t pkt_o,
  input  logic                 pkt_ready_i
);

  // Output register
  logic                 pkt_valid_q;
  pipe_pkg::issue_pkt_t pkt_q;

  // Packet assembled from the current request
  pipe_pkg::issue_pkt_t pkt_d;

  // Capture condition
  logic take;

  // --------------------
  // Operand read
  // --------------------
  // Indices straight from the queue head
  assign rs1_idx_o = req_i.rs1_idx;
  assign rs2_idx_o = req_i.rs2_idx;

  always_comb begin
    pkt_d.tag       = req_i.tag;
    pkt_d.rs1_value = rs1_value_i;
    pkt_d.rs2_value = rs2_value_i;
  end

  // --------------------
  // Capture control
  // --------------------
  // Register free, or its packet leaves this cycle
  assign take      = req_valid_i && (!pkt_valid_q || pkt_ready_i);
  // Queue head consumed only when captured
  assign req_pop_o = take;

  // Valid flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pkt_valid_q <= 1'b0;
    end else if (take) begin
      pkt_valid_q <= 1'b1;
    end else if (pkt_ready_i) begin
      // Drained with nothing behind it
      pkt_valid_q <= 1'b0;
    end
  end

  // Packet payload, unchanged while stalled
  always_ff @(posedge clk_i) begin
    if (take) begin
      pkt_q <= pkt_d;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign pkt_valid_o = pkt_valid_q;
  assign pkt_o       = pkt_q;

endmodule

`default_nettype wire

// ==== hdl/rf_stage_top.sv ====
// Register-file stage top: issue and commit queues, operand fetch, integer register file
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module rf_stage_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Issue requests in
  input  logic                 issue_valid_i,
  input  pipe_pkg::issue_req_t issue_req_i,
  output logic                 issue_ready_o,

  // Issue packets out
  output logic                 pkt_valid_o,
  output pipe_pkg::issue_pkt_t pkt_o,
  input  logic                 pkt_ready_i,

  // Commit records in
  input  logic                 comm_valid_i,
  input  pipe_pkg::commit_t    comm_i,
  output logic                 comm_ready_o
);

  // --------------------
  // Internal wires
  // --------------------
  // Issue queue head
  logic                 iq_valid;
  logic                 iq_full;
  logic                 iq_pop;
  pipe_pkg::issue_req_t iq_head;

  // Commit queue head
  logic                 cq_valid;
  logic                 cq_full;
  pipe_pkg::commit_t    cq_head;

  // Read ports
  isa_pkg::reg_idx_t    rs1_idx;
  isa_pkg::reg_idx_t    rs2_idx;
  isa_pkg::xword_t      rs1_value;
  isa_pkg::xword_t      rs2_value;

  assign issue_ready_o = !iq_full;
  assign comm_ready_o  = !cq_full;

  // --------------------
  // Issue path
  // --------------------
  sync_fifo #(
    .payload_t (pipe_pkg::issue_req_t),
    .DEPTH     (`RF_ISSUE_DEPTH)
  ) issue_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (issue_valid_i),
    .wdata_i (issue_req_i),
    .full_o  (iq_full),
    .pop_i   (iq_pop),
    .rdata_o (iq_head),
    .valid_o (iq_valid)
  );

  operand_fetch u_operand_fetch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (iq_valid),
    .req_i       (iq_head),
    .req_pop_o   (iq_pop),
    .rs1_idx_o   (rs1_idx),
    .rs2_idx_o   (rs2_idx),
    .rs1_value_i (rs1_value),
    .rs2_value_i (rs2_value),
    .pkt_valid_o (pkt_valid_o),
    .pkt_o       (pkt_o),
    .pkt_ready_i (pkt_ready_i)
  );

  // --------------------
  // Commit path
  // --------------------
  // Register file never stalls, head drains every non-empty cycle
  sync_fifo #(
    .payload_t (pipe_pkg::commit_t),
    .DEPTH     (`RF_COMMIT_DEPTH)
  ) commit_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (comm_valid_i),
    .wdata_i (comm_i),
    .full_o  (cq_full),
    .pop_i   (cq_valid),
    .rdata_o (cq_head),
    .valid_o (cq_valid)
  );

  int_rf u_int_rf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_valid_i  (cq_valid),
    .wr_i        (cq_head),
    .rs1_idx_i   (rs1_idx),
    .rs2_idx_i   (rs2_idx),
    .rs1_value_o (rs1_value),
    .rs2_value_o (rs2_value)
  );

endmodule

`default_nettype wire

// ==== sim/rf_stage_assertions.sv ====
// Bound checker for the register-file stage with back-pressure and x0 read assertions
`timescale 1ns/1ps
`default_nettype none

module rf_stage_assertions (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_ready_i,
  input  logic                 pkt_valid_i,
  input  pipe_pkg::issue_pkt_t pkt_i,
  input  logic                 pkt_ready_i,
  input  isa_pkg::reg_idx_t    rs1_idx_i,
  input  isa_pkg::reg_idx_t    rs2_idx_i,
  input  isa_pkg::xword_t      rs1_value_i,
  input  isa_pkg::xword_t      rs2_value_i
);

  // Count of failed assertions
  int fail_cnt = 0;

  // --------------------
  // Back-pressure
  // --------------------
  // Issue queue only fills behind a held packet
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !issue_ready_i |-> pkt_valid_i)
  else begin
    $error("issue queue full while no packet is held");
    fail_cnt++;
  end

  // Packet held unchanged under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pkt_valid_i && !pkt_ready_i |=> pkt_valid_i && $stable(pkt_i))
  else begin
    $error("issue packet dropped or changed while stalled");
    fail_cnt++;
  end

  // --------------------
  // Register file reads
  // --------------------
  // x0 reads zero on both ports
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs1_idx_i == '0 |-> rs1_value_i == '0)
  else begin
    $error("rs1 read of x0 returned nonzero");
    fail_cnt++;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs2_idx_i == '0 |-> rs2_value_i == '0)
  else begin
    $error("rs2 read of x0 returned nonzero");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// ==== sim/tb_rf_stage.sv ====
// Testbench for rf_stage_top with clock, reset, stimulus, reference register model and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

bind rf_stage_top rf_stage_assertions u_checks (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .issue_ready_i (issue_ready_o),
  .pkt_valid_i   (pkt_valid_o),
  .pkt_i         (pkt_o),
  .pkt_ready_i   (pkt_ready_i),
  .rs1_idx_i     (rs1_idx),
  .rs2_idx_i     (rs2_idx),
  .rs1_value_i   (rs1_value),
  .rs2_value_i   (rs2_value)
);

module tb_rf_stage;

  localparam int CLK_PERIOD = 40;
  // Summed cycle budget of all tests
  localparam int TEST_CYCLES = 60 + 90 + 30 + 60 + 70 + 40;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic issue_valid_i = 1'b0;
  pipe_pkg::issue_req_t issue_req_i = '0;
  logic issue_ready_o;
  logic pkt_valid_o;
  pipe_pkg::issue_pkt_t pkt_o;
  logic pkt_ready_i = 1'b1;
  logic comm_valid_i = 1'b0;
  pipe_pkg::commit_t comm_i = '0;
  logic comm_ready_o;

  // Reference model and scoreboard
  isa_pkg::xword_t ref_rf [`RF_XREG_NUM];
  pipe_pkg::issue_pkt_t exp_q [$];
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int streak = 0;
  int max_streak = 0;
  integer seed = 32'h9db83e36;

  rf_stage_top uut (.*);

  initial begin
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    #(TEST_CYCLES * 4 * CLK_PERIOD);
    $display("Watchdog expired: the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic expect_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("FAIL @ %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  // Testbench errors plus bound assertion failures
  function automatic int error_count();
    return errors + uut.u_checks.fail_cnt;
  endfunction

  // --------------------
  // Monitor and reference model
  // --------------------
  // Samples a quarter period after the falling edge
  // Inputs and outputs are settled well ahead of the next rising edge
  initial begin
    pipe_pkg::issue_pkt_t exp;
    for (int i = 0; i < `RF_XREG_NUM; i++) ref_rf[i] = '0;
    forever begin
      @(negedge clk_i);
      #(CLK_PERIOD/4);
      if (rst_ni) begin
        if (issue_valid_i && issue_ready_o) begin
          exp.tag = issue_req_i.tag;
          exp.rs1_value = ref_rf[issue_req_i.rs1_idx];
          exp.rs2_value = ref_rf[issue_req_i.rs2_idx];
          exp_q.push_back(exp);
        end
        if (comm_valid_i && comm_ready_o && comm_i.rd_idx != '0) begin
          ref_rf[comm_i.rd_idx] = comm_i.rd_value;
        end
        if (pkt_valid_o && pkt_ready_i) begin
          streak++;
          if (streak > max_streak) max_streak = streak;
          if (exp_q.size() == 0) begin
            expect_true(1'b0, $sformatf("unexpected packet, tag %0d", pkt_o.tag));
          end else begin
            exp = exp_q.pop_front();
            expect_true(pkt_o == exp, $sformatf("packet tag %0d rs1 %h rs2 %h, expected %0d %h %h",
              pkt_o.tag, pkt_o.rs1_value, pkt_o.rs2_value, exp.tag, exp.rs1_value,
              exp.rs2_value));
          end
        end else begin
          streak = 0;
        end
      end
    end
  end

  // --------------------
  // Drivers called on a falling edge
  // --------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic send_issue(input int tag, input int rs1, input int rs2);
    bit hs;
    issue_valid_i = 1'b1;
    issue_req_i.tag = pipe_pkg::tag_t'(tag);
    issue_req_i.rs1_idx = isa_pkg::reg_idx_t'(rs1);
    issue_req_i.rs2_idx = isa_pkg::reg_idx_t'(rs2);
    do begin
      #(CLK_PERIOD/4);
      hs = issue_ready_o;
      @(negedge clk_i);
    end while (!hs);
    issue_valid_i = 1'b0;
  endtask

  task automatic send_commit(input int idx, input isa_pkg::xword_t value);
    bit hs;
    comm_valid_i = 1'b1;
    comm_i.rd_idx = isa_pkg::reg_idx_t'(idx);
    comm_i.rd_value = value;
    do begin
      #(CLK_PERIOD/4);
      hs = comm_ready_o;
      @(negedge clk_i);
    end while (!hs);
    comm_valid_i = 1'b0;
  endtask

  // Commit queue drains into the register file
  task automatic settle_commits();
    wait_cycles(`RF_COMMIT_DEPTH + 2);
  endtask

  task automatic wait_packets();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 40) begin
      @(negedge clk_i);
      n++;
    end
    wait_cycles(1);
    expect_true(exp_q.size() == 0, $sformatf("%0d packets never arrived", exp_q.size()));
  endtask

  task automatic end_test(input string name, input int errs_before);
    int errs_now;
    errs_now = error_count();
    tests++;
    if (errs_now != errs_before) failed_tests++;
    $display("Test %0d %s: %s", tests, name, (errs_now == errs_before) ? "ok" : "failed");
  endtask

  // --------------------
  // Tests
  // --------------------
  initial begin
    int e;
    int idx;
    int used [12];
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    wait_cycles(1);

    // Reset state and zero reads of every register
    e = error_count();
    expect_true(!pkt_valid_o, "pkt_valid_o high before first issue");
    expect_true(issue_ready_o && comm_ready_o, "ready output low after reset");
    for (int i = 0; i < 16; i++) send_issue(i, 2 * i, 2 * i + 1);
    wait_packets();
    end_test("reset reads", e);

    // Random commits followed by reads
    // Last write to a register wins
    e = error_count();
    for (int k = 0; k < 10; k++) begin
      idx = $random(seed) & 31;
      if (idx == 0) idx = 1;
      used[k] = idx;
      send_commit(idx, $random(seed));
    end
    send_commit(used[3], 32'h1111_0000);
    send_commit(used[3], 32'h2222_ffff);
    used[10] = used[3];
    used[11] = 0;
    settle_commits();
    for (int k = 0; k < 11; k++) send_issue(k, used[k], used[k + 1]);
    wait_packets();
    end_test("random commits", e);

    // Write to x0 is dropped
    e = error_count();
    send_commit(0, 32'hdead_beef);
    settle_commits();
    send_issue(5, 0, 0);
    wait_packets();
    end_test("x0 write", e);

    // Back-pressure fills the issue queue
    // Release drains it in order
    e = error_count();
    pkt_ready_i = 1'b0;
    fork
      begin
        for (int k = 0; k < 8; k++) send_issue(k, k, 31 - k);
      end
      begin
        wait_cycles(12);
        expect_true(!issue_ready_o, "issue_ready_o stayed high with queue full");
        pkt_ready_i = 1'b1;
      end
    join
    wait_packets();
    end_test("back-pressure", e);

    // Commit burst followed by reads of every register
    e = error_count();
    for (int k = 1; k < 13; k++) send_commit(k * 2 + (k & 1), $random(seed));
    settle_commits();
    for (int k = 0; k < 16; k++) send_issue(k, 2 * k, 2 * k + 1);
    wait_packets();
    end_test("commit burst", e);

    // Throughput with pkt_ready_i high
    e = error_count();
    max_streak = 0;
    for (int k = 0; k < 8; k++) send_issue(k, k + 1, k + 2);
    wait_packets();
    expect_true(max_streak >= 8, $sformatf("longest packet run %0d, expected 8", max_streak));
    end_test("throughput", e);

    errors = error_count();
    $display("Tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/sync_fifo.sv
hdl/int_rf.sv
hdl/operand_fetch.sv
hdl/rf_stage_top.sv
sim/rf_stage_assertions.sv
sim/tb_rf_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the register-file stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rf_stage -f flist.f -o tb_rf_stage > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_rf_stage > "$LOG" 2>&1 || true

grep -qx "PASS: all tests" "$LOG" && echo "Simulation passed" \
  || { echo "Simulation failed, see $LOG"; exit 1; }
